//--- cpuDatapath.f
common/cpuPkg.sv
common/ctrlIf.sv
verilog/regFile.sv
decode/instrDecode.sv
execute/aluExecute.sv
result/resultRoute.sv
verilog/memAxiMaster.sv
verilog/cpuDatapath.sv
dv/cpuDatapath_asserts.sv
dv/cpuDatapath_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP = cpuDatapath_tb
FILELIST = cpuDatapath.f
BUILDDIR = obj_dir
LOG = sim.log
RUNFLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: compile
	./$(BUILDDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- dv/cpuDatapath_tb.sv
module cpuDatapath_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int Rows = 12;
    localparam int Instrs = Rows * 4 + 1;
    localparam int WatchdogCycles = Rows * 4 * 40 + 200;
    localparam logic [31:0] ResetPc = 32'd4;

    typedef struct packed {
        logic [4:0] op;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] addr; // word address of the store
    } rowT;

    rowT stimulus [Rows] = '{
        '{cpuPkg::add,   100,          -25,     200},
        '{cpuPkg::sub,   7,            20,      201},
        '{cpuPkg::andOp, 32'h0002AAAA, 32'hFFF0, 202},
        '{cpuPkg::orOp,  -5,           0,       203}, // ldi sign extension
        '{cpuPkg::shr,   -1,           31,      204},
        '{cpuPkg::shr,   1000,         0,       205},
        '{cpuPkg::shl,   3,            31,      206},
        '{cpuPkg::shl,   -7,           4,       207},
        '{cpuPkg::neg,   0,            12345,   208},
        '{cpuPkg::notOp, 0,            -262144, 209},
        '{5'b01111,      9,            9,       210}, // unknown code, r1 unchanged
        '{cpuPkg::sub,   -262144,      262143,  211}
    };

    logic Clock = 1'b0;
    logic rst;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic arvalid, arready, rvalid, rready;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic [1:0] rresp, bresp;
    logic [3:0] wstrb;
    logic halted;

    logic [31:0] mem [256];
    logic [31:0] readLog [$];
    logic [31:0] storeAddrLog [$];
    logic [31:0] storeDataLog [$];
    logic [3:0] storeStrbLog [$];
    time readTime [$];
    time storeTime [$];
    int validAfterHalt = 0;
    int passCount = 0;
    int failCount = 0;

    cpuDatapath #(.ResetPc(ResetPc)) dut0 (
        .Clock(Clock), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid),
        .awready(awready), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .halted(halted)
    );

    always #5 Clock = ~Clock;

    function automatic logic [31:0] immInstr(logic [4:0] op, logic [3:0] ra, logic [31:0] imm);
        return {op, ra, 4'd0, imm[18:0]};
    endfunction

    function automatic logic [31:0] aluInstr(logic [4:0] op, logic [3:0] ra, logic [3:0] rb,
                                             logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    // value of r1 after op r1,r2,r3 with r2 = b and r3 = c
    function automatic logic [31:0] expectedValue(logic [4:0] op, logic [31:0] b,
                                                  logic [31:0] c, logic [31:0] prev);
        case (op)
            cpuPkg::add:   return b + c;
            cpuPkg::sub:   return b - c;
            cpuPkg::andOp: return b & c;
            cpuPkg::orOp:  return b | c;
            cpuPkg::shr:   return b >> c[4:0];
            cpuPkg::shl:   return b << c[4:0];
            cpuPkg::neg:   return -c;
            cpuPkg::notOp: return ~c;
            default:       return prev;
        endcase
    endfunction

    task automatic waitRandomCycles();
        int n;
        n = $urandom_range(3, 0);
        repeat (n) @(negedge Clock);
    endtask

    task automatic reportMismatch(time at, string name, logic [31:0] want, logic [31:0] got);
        $display("MISMATCH at %0d ns: %s expected %h got %h", at, name, want, got);
    endtask

    task automatic finishTest(string name, bit ok);
        if (ok) begin
            passCount++;
            $display("%s: ok", name);
        end else begin
            failCount++;
            $display("%s: failed", name);
        end
    endtask

    // AXI read channel of the memory model
    initial begin
        logic [31:0] addr;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = '0;
        forever begin
            @(negedge Clock);
            if (arvalid) begin
                addr = araddr;
                waitRandomCycles();
                arready = 1'b1;
                @(negedge Clock);
                arready = 1'b0;
                readLog.push_back(addr);
                readTime.push_back($time);
                waitRandomCycles();
                rdata = mem[addr[9:2]];
                rvalid = 1'b1;
                while (!rready) @(negedge Clock);
                @(negedge Clock);
                rvalid = 1'b0;
            end
        end
    end

    // AXI write channels, aw and w accepted independently
    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] strb;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = '0;
        forever begin
            @(negedge Clock);
            if (awvalid) begin
                addr = awaddr;
                fork
                    begin
                        waitRandomCycles();
                        awready = 1'b1;
                        @(negedge Clock);
                        awready = 1'b0;
                    end
                    begin
                        waitRandomCycles();
                        while (!wvalid) @(negedge Clock);
                        data = wdata;
                        strb = wstrb;
                        wready = 1'b1;
                        @(negedge Clock);
                        wready = 1'b0;
                    end
                join
                mem[addr[9:2]] = data;
                storeAddrLog.push_back(addr);
                storeDataLog.push_back(data);
                storeStrbLog.push_back(strb);
                storeTime.push_back($time);
                waitRandomCycles();
                bvalid = 1'b1;
                while (!bready) @(negedge Clock);
                @(negedge Clock);
                bvalid = 1'b0;
            end
        end
    end

    always @(negedge Clock) begin
        if (!rst && halted && (arvalid || awvalid)) validAfterHalt++;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge Clock);
        if (!halted) begin
            $display("ERROR: the DUT did not halt within %0d cycles", WatchdogCycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [31:0] r1;
        logic [31:0] want [Rows];
        logic [31:0] pc;
        bit ok;
        void'($urandom(36));
        rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'hA5, i[7:0], ~i[7:0], i[7:0]}; // decodes as a no-op
        end
        pc = ResetPc;
        r1 = '0;
        for (int i = 0; i < Rows; i++) begin
            mem[pc] = immInstr(cpuPkg::ldi, 4'd2, stimulus[i].b);
            mem[pc + 1] = immInstr(cpuPkg::ldi, 4'd3, stimulus[i].c);
            mem[pc + 2] = aluInstr(stimulus[i].op, 4'd1, 4'd2, 4'd3);
            mem[pc + 3] = immInstr(cpuPkg::st, 4'd1, stimulus[i].addr);
            pc = pc + 4;
            r1 = expectedValue(stimulus[i].op, stimulus[i].b, stimulus[i].c, r1);
            want[i] = r1;
        end
        mem[pc] = {cpuPkg::halt, 27'd0};

        repeat (10) @(negedge Clock);
        rst = 1'b0;
        while (!halted) @(negedge Clock);
        repeat (20) @(negedge Clock); // time for stray requests after halt

        ok = (readLog.size() == Instrs);
        if (!ok) $display("ERROR: %0d instruction reads seen, expected %0d", readLog.size(), Instrs);
        for (int k = 0; k < readLog.size(); k++) begin
            if (readLog[k] !== (ResetPc + k) * 4) begin
                reportMismatch(readTime[k], "araddr", (ResetPc + k) * 4, readLog[k]);
                ok = 0;
            end
        end
        finishTest("fetch addresses", ok);

        for (int i = 0; i < Rows; i++) begin
            ok = 1;
            if (i >= storeAddrLog.size()) begin
                $display("ERROR: row %0d produced no store", i);
                ok = 0;
            end else begin
                if (storeAddrLog[i] !== stimulus[i].addr * 4) begin
                    reportMismatch(storeTime[i], "awaddr", stimulus[i].addr * 4, storeAddrLog[i]);
                    ok = 0;
                end
                if (storeDataLog[i] !== want[i]) begin
                    reportMismatch(storeTime[i], "wdata", want[i], storeDataLog[i]);
                    ok = 0;
                end
                if (storeStrbLog[i] !== 4'hF) begin
                    reportMismatch(storeTime[i], "wstrb", 32'hF, storeStrbLog[i]);
                    ok = 0;
                end
            end
            finishTest($sformatf("row %0d op %b b %0d c %0d", i, stimulus[i].op,
                                 $signed(stimulus[i].b), $signed(stimulus[i].c)), ok);
        end

        ok = (storeAddrLog.size() == Rows);
        if (!ok) $display("ERROR: %0d stores seen, expected %0d", storeAddrLog.size(), Rows);
        finishTest("store count", ok);

        ok = (validAfterHalt == 0);
        if (!ok) $display("ERROR: a read or write request was raised after halt");
        finishTest("quiet after halt", ok);

        ok = (dut0.asserts0.failures == 0);
        if (!ok) $display("ERROR: %0d protocol assertions failed", dut0.asserts0.failures);
        finishTest("protocol assertions", ok);

        $display("tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- dv/cpuDatapath_asserts.sv
module cpuDatapath_asserts (
    input  logic Clock,
    input  logic rst,
    input  logic [31:0] araddr,
    input  logic arvalid,
    input  logic arready,
    input  logic rready,
    input  logic [31:0] awaddr,
    input  logic awvalid,
    input  logic awready,
    input  logic [31:0] wdata,
    input  logic wvalid,
    input  logic wready,
    input  logic bready,
    input  logic halted
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    arHold: assert property (@(posedge Clock) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            failures++;
            $error("arvalid dropped or araddr changed before arready");
        end

    awHold: assert property (@(posedge Clock) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            failures++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    wHold: assert property (@(posedge Clock) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else begin
            failures++;
            $error("wvalid dropped or wdata changed before wready");
        end

    // single outstanding access
    oneAccess: assert property (@(posedge Clock) disable iff (rst)
        !((arvalid || rready) && (awvalid || wvalid || bready)))
        else begin
            failures++;
            $error("read and write outstanding together");
        end

    quietHalt: assert property (@(posedge Clock) disable iff (rst)
        halted |-> !arvalid && !awvalid && !wvalid)
        else begin
            failures++;
            $error("valid raised while halted");
        end

endmodule

bind cpuDatapath cpuDatapath_asserts asserts0 (
    .Clock(Clock), .rst(rst),
    .araddr(araddr), .arvalid(arvalid), .arready(arready), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bready(bready), .halted(halted)
);

//--- verilog/cpuDatapath.sv
module cpuDatapath #(
    parameter logic [31:0] ResetPc = '0
) (
    input  logic Clock,
    input  logic rst,
    output logic [31:0] araddr,
    output logic arvalid,
    input  logic arready,
    input  logic [31:0] rdata,
    input  logic [1:0] rresp,
    input  logic rvalid,
    output logic rready,
    output logic [31:0] awaddr,
    output logic awvalid,
    output logic [31:0] wdata,
    output logic [3:0] wstrb,
    output logic wvalid,
    input  logic awready,
    input  logic wready,
    input  logic [1:0] bresp,
    input  logic bvalid,
    output logic bready,
    output logic halted
);

    logic [31:0] busValue;
    logic [31:0] readValue;
    logic [31:0] zValue;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic memRead, memWrite, memDone;

    ctrlIf ctrl ();

    instrDecode #(.ResetPc(ResetPc)) decode0 (
        .Clock(Clock), .rst(rst), .busValue(busValue), .ctrl(ctrl.decode), .halted(halted)
    );

    aluExecute exec0 (
        .Clock(Clock), .rst(rst), .busValue(busValue), .ctrl(ctrl.exec), .zValue(zValue)
    );

    regFile regs0 (
        .Clock(Clock), .rst(rst), .busValue(busValue), .ctrl(ctrl.regs), .readValue(readValue)
    );

    resultRoute route0 (
        .Clock(Clock), .rst(rst), .ctrl(ctrl.route),
        .readValue(readValue), .zValue(zValue), .busValue(busValue),
        .memAddr(memAddr), .memWdata(memWdata), .memRead(memRead), .memWrite(memWrite),
        .memRdata(memRdata), .memDone(memDone)
    );

    memAxiMaster axi0 (
        .Clock(Clock), .rst(rst),
        .memAddr(memAddr), .memWdata(memWdata), .memRead(memRead), .memWrite(memWrite),
        .memRdata(memRdata), .memDone(memDone),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

endmodule

//--- verilog/memAxiMaster.sv
module memAxiMaster (
    input  logic Clock,
    input  logic rst,
    input  logic [cpuPkg::DataWidth-1:0] memAddr,
    input  logic [cpuPkg::DataWidth-1:0] memWdata,
    input  logic memRead,
    input  logic memWrite,
    output logic [cpuPkg::DataWidth-1:0] memRdata,
    output logic memDone,
    output logic [31:0] araddr,
    output logic arvalid,
    input  logic arready,
    input  logic [31:0] rdata,
    input  logic [1:0] rresp,
    input  logic rvalid,
    output logic rready,
    output logic [31:0] awaddr,
    output logic awvalid,
    input  logic awready,
    output logic [31:0] wdata,
    output logic [3:0] wstrb,
    output logic wvalid,
    input  logic wready,
    input  logic [1:0] bresp,
    input  logic bvalid,
    output logic bready
);

    typedef enum logic [2:0] {
        MemIdle, ReadAddr, ReadData, WriteAddrData, WriteResp
    } axiStateT;

    axiStateT state;
    logic awPending, wPending; // still unaccepted after this cycle

    assign awPending = awvalid && !awready;
    assign wPending = wvalid && !wready;

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= MemIdle;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
        end else begin
            case (state)
                MemIdle: begin
                    if (memRead) begin
                        arvalid <= 1'b1;
                        state <= ReadAddr;
                    end else if (memWrite) begin
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                        state <= WriteAddrData;
                    end
                end
                ReadAddr: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state <= ReadData;
                    end
                end
                ReadData: if (rvalid) state <= MemIdle;
                WriteAddrData: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (!awPending && !wPending) state <= WriteResp;
                end
                WriteResp: if (bvalid) state <= MemIdle;
                default: state <= MemIdle;
            endcase
        end
    end

    // word address to byte address, held until the next request
    always_ff @(posedge Clock) begin
        if (state == MemIdle && (memRead || memWrite)) begin
            araddr <= {memAddr[cpuPkg::DataWidth-3:0], 2'b00};
            awaddr <= {memAddr[cpuPkg::DataWidth-3:0], 2'b00};
            wdata <= memWdata;
        end
    end

    assign wstrb = 4'hF;
    assign rready = (state == ReadData);
    assign bready = (state == WriteResp);
    assign memRdata = rdata;
    assign memDone = (state == ReadData && rvalid) || (state == WriteResp && bvalid); // resp ignored

endmodule

//--- result/resultRoute.sv
module resultRoute (
    input  logic Clock,
    input  logic rst,
    ctrlIf.route ctrl,
    input  logic [cpuPkg::DataWidth-1:0] readValue,
    input  logic [cpuPkg::DataWidth-1:0] zValue,
    output logic [cpuPkg::DataWidth-1:0] busValue,
    output logic [cpuPkg::DataWidth-1:0] memAddr,
    output logic [cpuPkg::DataWidth-1:0] memWdata,
    output logic memRead,
    output logic memWrite,
    input  logic [cpuPkg::DataWidth-1:0] memRdata,
    input  logic memDone
);

    logic [cpuPkg::DataWidth-1:0] mar;
    logic [cpuPkg::DataWidth-1:0] mdr;
    logic readPending; // done belongs to a read

    always_comb begin
        case (ctrl.busSrc)
            cpuPkg::Reg:  busValue = readValue;
            cpuPkg::Zlow: busValue = zValue;
            cpuPkg::Mdr:  busValue = mdr;
            cpuPkg::Imm:  busValue = ctrl.immValue;
            cpuPkg::Pc:   busValue = ctrl.pcValue;
            default:      busValue = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            readPending <= 1'b0;
        end else if (memDone) begin
            readPending <= 1'b0;
        end else if (ctrl.memRead) begin
            readPending <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.marLoad) mar <= busValue;
        if (memDone && readPending) mdr <= memRdata;
    end

    assign memAddr = mar;
    assign memWdata = busValue; // ra stays on the bus through store T4
    assign memRead = ctrl.memRead;
    assign memWrite = ctrl.memWrite;
    assign ctrl.memDone = memDone;

endmodule

//--- execute/aluExecute.sv
module aluExecute (
    input  logic Clock,
    input  logic rst,
    input  logic [cpuPkg::DataWidth-1:0] busValue,
    ctrlIf.exec ctrl,
    output logic [cpuPkg::DataWidth-1:0] zValue
);

    logic [cpuPkg::DataWidth-1:0] y;
    logic [cpuPkg::DataWidth-1:0] aluResult;
    logic [4:0] shamt;

    assign shamt = busValue[4:0];

    // Y is the first operand, the bus carries the second
    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::add:   aluResult = y + busValue;
            cpuPkg::sub:   aluResult = y - busValue;
            cpuPkg::andOp: aluResult = y & busValue;
            cpuPkg::orOp:  aluResult = y | busValue;
            cpuPkg::shr:   aluResult = y >> shamt; // logical
            cpuPkg::shl:   aluResult = y << shamt;
            cpuPkg::neg:   aluResult = -busValue;
            cpuPkg::notOp: aluResult = ~busValue;
            default:       aluResult = busValue;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            y <= '0;
        end else if (ctrl.yLoad) begin
            y <= busValue;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            zValue <= '0;
        end else if (ctrl.zLoad) begin
            zValue <= aluResult;
        end
    end

endmodule

//--- decode/instrDecode.sv
module instrDecode #(
    parameter logic [cpuPkg::DataWidth-1:0] ResetPc = '0
) (
    input  logic Clock,
    input  logic rst,
    input  logic [cpuPkg::DataWidth-1:0] busValue,
    ctrlIf.decode ctrl,
    output logic halted
);

    cpuPkg::stepT step;
    logic [cpuPkg::DataWidth-1:0] pc;
    logic [cpuPkg::DataWidth-1:0] ir;
    logic memIssued; // request of the current T1 or T4 already sent
    cpuPkg::opcodeT opcode;
    logic [3:0] ra, rb, rc;
    logic isAlu;
    logic issueRead, issueWrite;

    function automatic logic aluClass(cpuPkg::opcodeT op);
        case (op)
            cpuPkg::add, cpuPkg::sub, cpuPkg::andOp, cpuPkg::orOp,
            cpuPkg::shr, cpuPkg::shl, cpuPkg::neg, cpuPkg::notOp: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign opcode = cpuPkg::opcodeT'(ir[cpuPkg::OpcodeMsb:cpuPkg::OpcodeLsb]);
    assign ra = ir[cpuPkg::RaMsb:cpuPkg::RaLsb];
    assign rb = ir[cpuPkg::RbMsb:cpuPkg::RbLsb];
    assign rc = ir[cpuPkg::RcMsb:cpuPkg::RcLsb];
    assign isAlu = aluClass(opcode);

    assign issueRead = (step == cpuPkg::T1) && !memIssued;
    assign issueWrite = (step == cpuPkg::T4) && (opcode == cpuPkg::st) && !memIssued;

    assign ctrl.memRead = issueRead;
    assign ctrl.memWrite = issueWrite;
    assign ctrl.aluOp = opcode;
    assign ctrl.pcValue = pc;
    assign ctrl.immValue = {{(cpuPkg::DataWidth - cpuPkg::ImmWidth){ir[cpuPkg::ImmMsb]}},
                            ir[cpuPkg::ImmMsb:cpuPkg::ImmLsb]};
    assign halted = (step == cpuPkg::Halted);

    always_ff @(posedge Clock) begin
        if (rst) begin
            step <= cpuPkg::Idle;
            pc <= ResetPc;
            ir <= '0;
            memIssued <= 1'b0;
        end else begin
            if (ctrl.memDone) begin
                memIssued <= 1'b0;
            end else if (issueRead || issueWrite) begin
                memIssued <= 1'b1;
            end
            case (step)
                cpuPkg::Idle: step <= cpuPkg::T0;
                cpuPkg::T0: begin
                    pc <= pc + 1'b1; // word address
                    step <= cpuPkg::T1;
                end
                cpuPkg::T1: if (ctrl.memDone) step <= cpuPkg::T2;
                cpuPkg::T2: begin
                    ir <= busValue;
                    step <= cpuPkg::T3;
                end
                cpuPkg::T3: begin
                    if (isAlu || opcode == cpuPkg::st) step <= cpuPkg::T4;
                    else if (opcode == cpuPkg::halt) step <= cpuPkg::Halted;
                    else step <= cpuPkg::T0; // ldi done, unknown skipped
                end
                cpuPkg::T4: begin
                    if (isAlu) step <= cpuPkg::T5;
                    else if (ctrl.memDone) step <= cpuPkg::T0;
                end
                cpuPkg::T5: step <= cpuPkg::T0;
                cpuPkg::Halted: step <= cpuPkg::Halted; // until reset
                default: step <= cpuPkg::Idle;
            endcase
        end
    end

    always_comb begin
        ctrl.busSrc = cpuPkg::None;
        ctrl.regSel = '0;
        ctrl.regWrite = 1'b0;
        ctrl.yLoad = 1'b0;
        ctrl.zLoad = 1'b0;
        ctrl.marLoad = 1'b0;
        case (step)
            cpuPkg::T0: begin
                ctrl.busSrc = cpuPkg::Pc;
                ctrl.marLoad = 1'b1;
            end
            cpuPkg::T2: ctrl.busSrc = cpuPkg::Mdr;
            cpuPkg::T3: begin
                if (isAlu) begin
                    ctrl.busSrc = cpuPkg::Reg;
                    ctrl.regSel = rb;
                    ctrl.yLoad = 1'b1;
                end else if (opcode == cpuPkg::ldi) begin
                    ctrl.busSrc = cpuPkg::Imm;
                    ctrl.regSel = ra;
                    ctrl.regWrite = 1'b1;
                end else if (opcode == cpuPkg::st) begin
                    ctrl.busSrc = cpuPkg::Imm; // store address
                    ctrl.marLoad = 1'b1;
                end
            end
            cpuPkg::T4: begin
                ctrl.busSrc = cpuPkg::Reg;
                ctrl.regSel = isAlu ? rc : ra; // ra is the store data
                ctrl.zLoad = isAlu;
            end
            cpuPkg::T5: begin
                ctrl.busSrc = cpuPkg::Zlow;
                ctrl.regSel = ra;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/regFile.sv
module regFile (
    input  logic Clock,
    input  logic rst,
    input  logic [cpuPkg::DataWidth-1:0] busValue,
    ctrlIf.regs ctrl,
    output logic [cpuPkg::DataWidth-1:0] readValue
);

    logic [cpuPkg::DataWidth-1:0] regs [16];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            regs[ctrl.regSel] <= busValue; // lands at the next edge
        end
    end

    assign readValue = regs[ctrl.regSel];

endmodule

//--- common/ctrlIf.sv
interface ctrlIf;
    cpuPkg::busSrcT busSrc;
    logic [3:0] regSel; // register for read or write
    logic regWrite;
    logic yLoad;
    logic zLoad;
    cpuPkg::opcodeT aluOp;
    logic marLoad;
    logic memRead; // single cycle request pulses
    logic memWrite;
    logic [cpuPkg::DataWidth-1:0] immValue;
    logic [cpuPkg::DataWidth-1:0] pcValue;
    logic memDone;

    modport decode (
        output busSrc, regSel, regWrite, yLoad, zLoad, aluOp, marLoad,
        output memRead, memWrite, immValue, pcValue,
        input memDone
    );
    modport exec (input yLoad, zLoad, aluOp);
    modport route (
        input busSrc, marLoad, memRead, memWrite, immValue, pcValue,
        output memDone
    );
    modport regs (input regSel, regWrite);
endinterface

//--- common/cpuPkg.sv
package cpuPkg;

    parameter int DataWidth = 32;

    // instruction fields
    parameter int OpcodeMsb = 31;
    parameter int OpcodeLsb = 27;
    parameter int RaMsb = 26;
    parameter int RaLsb = 23;
    parameter int RbMsb = 22;
    parameter int RbLsb = 19;
    parameter int RcMsb = 18;
    parameter int RcLsb = 15;
    parameter int ImmMsb = 18;
    parameter int ImmLsb = 0;
    parameter int ImmWidth = 19;

    typedef enum logic [4:0] {
        ldi   = 5'b00001,
        st    = 5'b00010,
        add   = 5'b00011,
        sub   = 5'b00100,
        andOp = 5'b00101,
        orOp  = 5'b00110,
        shr   = 5'b00111,
        shl   = 5'b01000,
        neg   = 5'b01001,
        notOp = 5'b01010,
        halt  = 5'b11011
    } opcodeT; // other codes execute as no-op

    typedef enum logic [3:0] {
        Idle, T0, T1, T2, T3, T4, T5, Halted
    } stepT;

    typedef enum logic [2:0] {
        None, Reg, Zlow, Mdr, Imm, Pc
    } busSrcT;

endpackage
